// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // ALU group funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // CSR group funct3, bit 2 selects the immediate source
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Also CSR form: imm12 is the CSR address, rs1 is the 5-bit immediate
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
  } instr_t;

endpackage

`default_nettype wire

// ==== hw/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // Immediate CSR forms share these codes
  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LINK,
    WB_CSR
  } wb_src_e;

  ////////////////////////////////////////////////////////////////////////////
  // Stage-to-stage bundles
  ////////////////////////////////////////////////////////////////////////////

  // Decode to execute
  typedef struct packed {
    logic        valid;
    alu_op_e     alu_op;
    csr_op_e     csr_op;
    wb_src_e     wb_src;
    logic [4:0]  rd;
    logic        rd_we;
    logic [11:0] csr_addr;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] pc;
    logic        compressed;
    logic [31:0] csr_old;
  } dec_ctrl_t;

  // Execute to result
  typedef struct packed {
    logic        valid;
    wb_src_e     wb_src;
    logic [4:0]  rd;
    logic        rd_we;
    logic [31:0] alu_res;
    logic [31:0] link;
    logic [31:0] csr_old;
    logic [31:0] csr_new;
    csr_op_e     csr_op;
    logic [11:0] csr_addr;
  } exec_res_t;

endpackage

`default_nettype wire

// ==== hw/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        in_valid,
  input  wire instr_t      instr,
  input  wire logic [31:0] pc,
  input  wire logic [31:0] rs1_data,
  input  wire logic [31:0] rs2_data,
  input  wire logic [31:0] csr_rdata,
  input  wire logic        compressed,
  output dec_ctrl_t        ctrl
);

  // funct3 to ALU op; alt is instruction bit 30
  function automatic alu_op_e map_alu(input logic [2:0] f3, input logic alt,
                                      input logic reg_form);
    alu_op_e op;
    case (f3)
      F3_ADD_SUB: op = (alt && reg_form) ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
      default:    op = ALU_ADD;
    endcase
    return op;
  endfunction

  dec_ctrl_t   ctrl_d;
  logic        legal;
  csr_op_e     csr_dec;
  logic [31:0] i_imm;
  logic [31:0] u_imm;

  // Immediates
  assign i_imm = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
  assign u_imm = {instr.u_fmt.imm20, 12'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Field decode and operand select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_d            = '0;
    ctrl_d.alu_op     = ALU_ADD;
    ctrl_d.csr_op     = CSR_NONE;
    ctrl_d.wb_src     = WB_ALU;
    ctrl_d.rd         = instr.r_fmt.rd;
    ctrl_d.csr_addr   = instr.i_fmt.imm12;
    ctrl_d.pc         = pc;
    ctrl_d.compressed = compressed;
    ctrl_d.csr_old    = csr_rdata;
    legal             = 1'b1;
    csr_dec           = CSR_NONE;

    case (instr.r_fmt.opcode)
      OPC_OP: begin
        ctrl_d.op_a   = rs1_data;
        ctrl_d.op_b   = rs2_data;
        ctrl_d.alu_op = map_alu(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b1);
      end
      OPC_OP_IMM: begin
        // Shift amount sits in the low five immediate bits
        ctrl_d.op_a   = rs1_data;
        ctrl_d.op_b   = i_imm;
        ctrl_d.alu_op = map_alu(instr.i_fmt.funct3, instr.r_fmt.funct7[5], 1'b0);
      end
      OPC_LUI: begin
        ctrl_d.op_b = u_imm;
      end
      OPC_AUIPC: begin
        // Full PC plus upper immediate
        ctrl_d.op_a = pc;
        ctrl_d.op_b = u_imm;
      end
      OPC_JAL, OPC_JALR: begin
        ctrl_d.wb_src = WB_LINK;
      end
      OPC_SYSTEM: begin
        ctrl_d.wb_src = WB_CSR;
        // Zero-extended uimm or rs1 value
        ctrl_d.op_a = instr.i_fmt.funct3[2] ? {27'b0, instr.i_fmt.rs1} : rs1_data;
        case (instr.i_fmt.funct3)
          F3_CSRRW, F3_CSRRWI: csr_dec = CSR_RW;
          F3_CSRRS, F3_CSRRSI: csr_dec = CSR_RS;
          F3_CSRRC, F3_CSRRCI: csr_dec = CSR_RC;
          default:             csr_dec = CSR_NONE;
        endcase
        legal = (csr_dec != CSR_NONE);
        // Set/clear with x0 or zero uimm is a pure read
        if (csr_dec != CSR_RW && instr.i_fmt.rs1 == 5'd0)
          ctrl_d.csr_op = CSR_NONE;
        else
          ctrl_d.csr_op = csr_dec;
      end
      default: begin
        legal = 1'b0;
      end
    endcase

    ctrl_d.valid = in_valid;
    ctrl_d.rd_we = in_valid && legal && (instr.r_fmt.rd != 5'd0);
    if (!in_valid)
      ctrl_d.csr_op = CSR_NONE;
  end

  // Decode register; only control fields take reset
  always_ff @(posedge clk) begin
    ctrl <= ctrl_d;
    if (rst) begin
      ctrl.valid  <= 1'b0;
      ctrl.rd_we  <= 1'b0;
      ctrl.csr_op <= CSR_NONE;
    end
  end

endmodule

`default_nettype wire

// ==== hw/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute
  import exec_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire dec_ctrl_t ctrl,
  output exec_res_t      res
);

  logic [31:0] alu_y;
  logic [31:0] link;
  logic [31:0] csr_new;
  logic [4:0]  shamt;
  exec_res_t   res_d;

  assign shamt = ctrl.op_b[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_y = ctrl.op_a + ctrl.op_b;
      ALU_SUB:  alu_y = ctrl.op_a - ctrl.op_b;
      ALU_AND:  alu_y = ctrl.op_a & ctrl.op_b;
      ALU_OR:   alu_y = ctrl.op_a | ctrl.op_b;
      ALU_XOR:  alu_y = ctrl.op_a ^ ctrl.op_b;
      ALU_SLL:  alu_y = ctrl.op_a << shamt;
      ALU_SRL:  alu_y = ctrl.op_a >> shamt;
      ALU_SRA:  alu_y = $unsigned($signed(ctrl.op_a) >>> shamt);
      // Compares give 0 or 1
      ALU_SLT:  alu_y = {31'b0, $signed(ctrl.op_a) < $signed(ctrl.op_b)};
      ALU_SLTU: alu_y = {31'b0, ctrl.op_a < ctrl.op_b};
      default:  alu_y = 32'b0;
    endcase
  end

  // Return address stepping by 2 for compressed
  assign link = ctrl.pc + (ctrl.compressed ? 32'd2 : 32'd4);

  ////////////////////////////////////////////////////////////////////////////
  // CSR read-modify-write
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.csr_op)
      CSR_RW:  csr_new = ctrl.op_a;
      CSR_RS:  csr_new = ctrl.csr_old | ctrl.op_a;
      CSR_RC:  csr_new = ctrl.csr_old & ~ctrl.op_a;
      default: csr_new = ctrl.csr_old;
    endcase
  end

  always_comb begin
    res_d.valid    = ctrl.valid;
    res_d.wb_src   = ctrl.wb_src;
    res_d.rd       = ctrl.rd;
    res_d.rd_we    = ctrl.rd_we;
    res_d.alu_res  = alu_y;
    res_d.link     = link;
    res_d.csr_old  = ctrl.csr_old;
    res_d.csr_new  = csr_new;
    res_d.csr_op   = ctrl.csr_op;
    res_d.csr_addr = ctrl.csr_addr;
  end

  // Execute register
  always_ff @(posedge clk) begin
    res <= res_d;
    if (rst) begin
      res.valid  <= 1'b0;
      res.rd_we  <= 1'b0;
      res.csr_op <= CSR_NONE;
    end
  end

endmodule

`default_nettype wire

// ==== hw/writeback_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_select
  import exec_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire exec_res_t res,
  output logic           out_valid,
  output logic [4:0]     rd_addr,
  output logic           rd_we,
  output logic [31:0]    rd_data,
  output logic           csr_we,
  output logic [11:0]    csr_addr,
  output logic [31:0]    csr_wdata
);

  logic [31:0] rd_data_d;

  // Writeback source mux
  always_comb begin
    case (res.wb_src)
      WB_LINK: rd_data_d = res.link;
      WB_CSR:  rd_data_d = res.csr_old;
      default: rd_data_d = res.alu_res;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Commit register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    rd_addr   <= res.rd;
    rd_data   <= rd_data_d;
    csr_addr  <= res.csr_addr;
    csr_wdata <= res.csr_new;
    if (rst) begin
      out_valid <= 1'b0;
      rd_we     <= 1'b0;
      csr_we    <= 1'b0;
    end else begin
      out_valid <= res.valid;
      // Write enables only with a live instruction
      rd_we     <= res.valid && res.rd_we;
      csr_we    <= res.valid && (res.csr_op != CSR_NONE);
    end
  end

endmodule

`default_nettype wire

// ==== hw/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core
  import isa_pkg::*;
  import exec_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        in_valid,
  input  wire instr_t      instr,
  input  wire logic [31:0] pc,
  input  wire logic [31:0] rs1_data,
  input  wire logic [31:0] rs2_data,
  input  wire logic [31:0] csr_rdata,
  input  wire logic        compressed,
  output logic             out_valid,
  output logic [4:0]       rd_addr,
  output logic             rd_we,
  output logic [31:0]      rd_data,
  output logic             csr_we,
  output logic [11:0]      csr_addr,
  output logic [31:0]      csr_wdata
);

  ////////////////////////////////////////////////////////////////////////////
  // Decode, execute, commit
  ////////////////////////////////////////////////////////////////////////////

  dec_ctrl_t ctrl;
  exec_res_t res;

  instr_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .instr      (instr),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .csr_rdata  (csr_rdata),
    .compressed (compressed),
    .ctrl       (ctrl)
  );

  alu_execute u_execute (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl),
    .res  (res)
  );

  // Writes become visible here
  writeback_select u_writeback (
    .clk       (clk),
    .rst       (rst),
    .res       (res),
    .out_valid (out_valid),
    .rd_addr   (rd_addr),
    .rd_we     (rd_we),
    .rd_data   (rd_data),
    .csr_we    (csr_we),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  input  wire logic rst_req,
  output logic      clk,
  output logic      rst
);

  logic por;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Power-on reset over the first five edges
  initial begin
    por = 1'b1;
    repeat (5) @(posedge clk);
    #2 por = 1'b0;
  end

  // Mid-run reset on request
  assign rst = por | rst_req;

endmodule

`default_nettype wire

// ==== bench/exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb
  import isa_pkg::*;
();

  // Upper bound on issued instructions with up to three idle slots each
  localparam int ISSUE_BOUND = 420;
  localparam int WATCHDOG_NS = (ISSUE_BOUND * 4 + 200) * 20;
  localparam int N_MIX       = 150;

  typedef struct packed {
    int          due;
    logic        check_rd;
    logic [4:0]  rd_addr;
    logic        rd_we;
    logic [31:0] rd_data;
    logic        csr_we;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        rst_req;
  logic        in_valid;
  instr_t      instr;
  logic [31:0] pc;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] csr_rdata;
  logic        compressed;
  logic        out_valid;
  logic [4:0]  rd_addr;
  logic        rd_we;
  logic [31:0] rd_data;
  logic        csr_we;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;

  logic [31:0] lfsr;
  int          edge_cnt = 0;
  expect_t     exp_q[$];
  expect_t     head;

  tb_clock u_clock (
    .rst_req (rst_req),
    .clk     (clk),
    .rst     (rst)
  );

  exec_core DUT (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .instr      (instr),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .csr_rdata  (csr_rdata),
    .compressed (compressed),
    .out_valid  (out_valid),
    .rd_addr    (rd_addr),
    .rd_we      (rd_we),
    .rd_data    (rd_data),
    .csr_we     (csr_we),
    .csr_addr   (csr_addr),
    .csr_wdata  (csr_wdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
    end
    return val;
  endfunction

  // Bit 30 selects subtract or arithmetic shift
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] srl;
    logic        lt_s;
    srl  = a >> b[4:0];
    // Differing signs decide on their own
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, lt_s};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? srl | ({32{a[31]}} & ~(32'hFFFF_FFFF >> b[4:0])) : srl;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic expect_t model(input logic [31:0] w, input logic [31:0] a,
                                    input logic [31:0] b, input logic [31:0] old,
                                    input logic [31:0] pc_v, input logic c);
    expect_t     e;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] src;
    logic        ok;
    imm_i      = {{20{w[31]}}, w[31:20]};
    imm_u      = {w[31:12], 12'b0};
    // CSR source is the uimm when funct3 bit 2 is set
    src        = w[14] ? {27'b0, w[19:15]} : a;
    e          = '0;
    e.rd_addr  = w[11:7];
    e.csr_addr = w[31:20];
    ok         = 1'b1;
    case (w[6:0])
      OPC_OP:            e.rd_data = alu_ref(w[14:12], w[30], a, b);
      OPC_OP_IMM:        e.rd_data = alu_ref(w[14:12], w[30] && w[14:12] == 3'd5, a, imm_i);
      OPC_LUI:           e.rd_data = imm_u;
      OPC_AUIPC:         e.rd_data = pc_v + imm_u;
      OPC_JAL, OPC_JALR: e.rd_data = pc_v + (c ? 32'd2 : 32'd4);
      OPC_SYSTEM: begin
        ok        = w[13:12] != 2'b00;
        e.rd_data = old;
        // Set or clear with a zero source writes nothing
        e.csr_we  = ok && (w[13:12] == 2'b01 || w[19:15] != 5'd0);
        case (w[13:12])
          2'b01:   e.csr_wdata = src;
          2'b10:   e.csr_wdata = old | src;
          default: e.csr_wdata = old & ~src;
        endcase
      end
      default: ok = 1'b0;
    endcase
    e.check_rd = ok;
    e.rd_we    = ok && w[11:7] != 5'd0;
    return e;
  endfunction

  // Kinds: 0 OP, 1 OP-IMM, 2 JALR, 3 CSR, 4 LUI, 5 AUIPC, 6 JAL
  function automatic logic [31:0] rand_word(input int kind, input logic [2:0] f3,
                                            input logic alt, input logic [4:0] rd);
    logic [11:0] imm;
    logic [4:0]  rs;
    imm = 12'(rand_bits(12));
    rs  = 5'(rand_bits(5));
    case (kind)
      0: return {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, imm[4:0], rs, f3, rd, OPC_OP};
      1: begin
        // Shift immediates hold the shift type in bit 30
        if (f3 == 3'd1 || f3 == 3'd5)
          imm = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]};
        return {imm, rs, f3, rd, OPC_OP_IMM};
      end
      2: return {imm, rs, 3'b000, rd, OPC_JALR};
      3: return {imm, rs, f3, rd, OPC_SYSTEM};
      4: return {imm, rs, f3, rd, OPC_LUI};
      5: return {imm, rs, f3, rd, OPC_AUIPC};
      default: return {imm, rs, f3, rd, OPC_JAL};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] want);
    assert (got === want) else begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
      $display("TEST FAIL");
      $fatal(1, "output mismatch on %s", name);
    end
  endtask

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  // Outputs sampled at the falling edge
  always @(negedge clk) begin
    if (edge_cnt > 0) begin
      if (exp_q.size() > 0 && exp_q[0].due == edge_cnt) begin
        head = exp_q.pop_front();
        check_val("out_valid", 32'(out_valid), 32'd1);
        check_val("rd_we", 32'(rd_we), 32'(head.rd_we));
        check_val("csr_we", 32'(csr_we), 32'(head.csr_we));
        if (head.check_rd) begin
          check_val("rd_addr", 32'(rd_addr), 32'(head.rd_addr));
          check_val("rd_data", rd_data, head.rd_data);
        end
        if (head.csr_we) begin
          check_val("csr_addr", 32'(csr_addr), 32'(head.csr_addr));
          check_val("csr_wdata", csr_wdata, head.csr_wdata);
        end
      end else begin
        // No commit expected when nothing is due
        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("rd_we", 32'(rd_we), 32'd0);
        check_val("csr_we", 32'(csr_we), 32'd0);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Result seen three edges after the driving edge
  task automatic issue(input logic [31:0] w, input logic [31:0] a,
                       input logic [31:0] b, input logic c);
    logic [31:0] old;
    logic [31:0] pc_v;
    expect_t     e;
    old  = rand_bits(32);
    pc_v = rand_bits(32) & 32'hFFFF_FFFE;
    @(posedge clk);
    #2;
    in_valid   = 1'b1;
    instr      = w;
    rs1_data   = a;
    rs2_data   = b;
    csr_rdata  = old;
    pc         = pc_v;
    compressed = c;
    e          = model(w, a, b, old, pc_v, c);
    e.due      = edge_cnt + 3;
    exp_q.push_back(e);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      in_valid = 1'b0;
    end
  endtask

  task automatic issue_random();
    int         kind;
    logic [2:0] f3;
    kind = int'(rand_bits(3));
    f3   = 3'(rand_bits(3));
    if (kind == 7)
      kind = 3;
    if (kind == 3 && f3[1:0] == 2'b00)
      f3[0] = 1'b1;
    issue(rand_word(kind, f3, rand_bits(1) != 0, 5'(rand_bits(5))),
          rand_bits(32), rand_bits(32), rand_bits(1) != 0);
  endtask

  // Whatever is still in flight is lost
  task automatic pulse_reset(input int n);
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    rst_req  = 1'b1;
    while (exp_q.size() > 0 && exp_q[$].due > edge_cnt)
      void'(exp_q.pop_back());
    repeat (n) @(posedge clk);
    #2;
    rst_req = 1'b0;
  endtask

  initial begin
    logic [31:0] w;
    logic [31:0] a;
    lfsr       = 32'h43d6;
    rst_req    = 1'b0;
    in_valid   = 1'b0;
    instr      = '0;
    pc         = '0;
    rs1_data   = '0;
    rs2_data   = '0;
    csr_rdata  = '0;
    compressed = 1'b0;
    repeat (5) @(posedge clk);

    // All ALU operations in register and immediate forms
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f == 0 || f == 5)
          repeat (6) issue(rand_word(0, 3'(f), alt == 1, 5'(rand_bits(5))),
                           rand_bits(32), rand_bits(32), 1'b0);
        if (alt == 0 || f == 5)
          repeat (6) issue(rand_word(1, 3'(f), alt == 1, 5'(rand_bits(5))),
                           rand_bits(32), rand_bits(32), 1'b0);
      end
    end
    a = rand_bits(32);
    issue(rand_word(0, 3'd2, 1'b0, 5'd3), a, a, 1'b0);
    issue(rand_word(0, 3'd3, 1'b0, 5'd4), a, a, 1'b0);
    // Destination x0
    issue(rand_word(0, 3'd0, 1'b0, 5'd0), rand_bits(32), rand_bits(32), 1'b0);
    issue(rand_word(1, 3'd6, 1'b0, 5'd0), rand_bits(32), rand_bits(32), 1'b0);

    // Upper immediates and links with both step sizes
    for (int c = 0; c < 2; c++)
      for (int k = 2; k < 7; k++)
        if (k != 3)
          repeat (3) issue(rand_word(k, 3'(rand_bits(3)), 1'b0, 5'(rand_bits(5))),
                           rand_bits(32), rand_bits(32), c == 1);

    // CSR forms and each with a zero source field
    for (int f = 1; f < 8; f++) begin
      if (f != 4) begin
        repeat (4) issue(rand_word(3, 3'(f), 1'b0, 5'(rand_bits(5))),
                         rand_bits(32), rand_bits(32), 1'b0);
        w = rand_word(3, 3'(f), 1'b0, 5'd9);
        w[19:15] = 5'd0;
        issue(w, rand_bits(32), rand_bits(32), 1'b0);
      end
    end

    // Mixed traffic with idle gaps
    repeat (N_MIX) begin
      issue_random();
      idle(int'(rand_bits(2)));
    end

    // Reset with work in flight
    repeat (3) issue_random();
    pulse_reset(2);
    idle(6);

    // Unsupported encodings still commit with no writes
    for (int u = 0; u < 6; u++) begin
      w      = rand_bits(32);
      w[7]   = 1'b1;
      case (u)
        0: w[6:0] = 7'b0000011;
        1: w[6:0] = 7'b0100011;
        2: w[6:0] = 7'b1100011;
        3: w[6:0] = 7'b0001111;
        default: begin
          w[6:0]   = OPC_SYSTEM;
          w[13:12] = 2'b00;
        end
      endcase
      issue(w, rand_bits(32), rand_bits(32), 1'b0);
    end
    repeat (20) begin
      issue_random();
      idle(int'(rand_bits(1)));
    end

    idle(1);
    while (exp_q.size() > 0)
      @(posedge clk);
    idle(4);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/isa_pkg.sv
hw/exec_pkg.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/writeback_select.sv
hw/exec_core.sv
bench/tb_clock.sv
bench/exec_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module exec_core_tb -f verilog.f -o exec_core_sim
./obj_dir/exec_core_sim
